//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_branch_fetch
FILELIST  := sources.f
BUILD_DIR := obj_dir
PASS_MSG  := All tests passed!

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

//--- rtl/bp_types_pkg.sv
// Branch predictor types
// Counter state encoding, tag width and the BHT and BTB entry layouts
`default_nettype none

package bp_types_pkg;

  ////////////////////////////////////////////////////////////
  // Tag geometry
  ////////////////////////////////////////////////////////////
  localparam int TAG_BITS = 12;  // PC[15:4] for a 3-bit index, PC[0] unused

  ////////////////////////////////////////////////////////////
  // 2-bit saturating counter
  ////////////////////////////////////////////////////////////
  // Bit 1 set means the branch is predicted taken
  typedef enum logic [1:0] {
    STRONG_NOT_TAKEN = 2'b00,
    WEAK_NOT_TAKEN   = 2'b01,
    WEAK_TAKEN       = 2'b10,
    STRONG_TAKEN     = 2'b11
  } bp_state_t;

  ////////////////////////////////////////////////////////////
  // Table entries
  ////////////////////////////////////////////////////////////
  typedef struct packed {
    logic                valid;  // Written since reset
    logic [TAG_BITS-1:0] tag;    // PC bits above the index
    bp_state_t           state;  // Counter value
  } bht_entry_t;

  typedef struct packed {
    logic                valid;   // Written since reset
    logic [TAG_BITS-1:0] tag;     // PC bits above the index
    logic [15:0]         target;  // Last resolved target
  } btb_entry_t;

endpackage

`default_nettype wire

//--- rtl/branch_fetch_top.sv
// Branch fetch top level
// Fetch PC unit and dynamic branch predictor wired together
`timescale 1ns/10ps
`default_nettype none

module branch_fetch_top
  import fetch_pkg::*;
#(
  parameter int  INDEX_BITS = 3,        // 8 entries per table
  parameter pc_t RESET_PC   = 16'h0000  // PC after reset
) (
  input  wire logic     clk,
  input  wire logic     rst,
  input  wire logic     enable,   // Stage enable
  input  wire resolve_t resolve,  // Packet from decode
  output pc_t           pc,       // Current fetch PC
  output predict_t      pred,     // Prediction for pc
  output if_id_t        if_id     // IF/ID register
);

  ////////////////////////////////////////////////////////////
  // Fetch unit
  ////////////////////////////////////////////////////////////
  fetch_pc_unit #(
    .RESET_PC (RESET_PC)
  ) u_fetch (
    .clk     (clk),
    .rst     (rst),
    .enable  (enable),
    .pred    (pred),     // Picks target when taken
    .resolve (resolve),  // Redirect fields
    .pc      (pc),
    .if_id   (if_id)
  );

  ////////////////////////////////////////////////////////////
  // Predictor
  ////////////////////////////////////////////////////////////
  branch_predictor #(
    .INDEX_BITS (INDEX_BITS)
  ) u_bp (
    .clk     (clk),
    .rst     (rst),
    .enable  (enable),
    .pc      (pc),       // Looked up in the same cycle
    .resolve (resolve),  // Write fields
    .pred    (pred)
  );

endmodule

`default_nettype wire

//--- rtl/branch_predictor.sv
// Dynamic branch predictor
// BHT of 2-bit counters and BTB of targets, both tagged, with the
// counter update rule and the tag-checked prediction for the fetch PC
`timescale 1ns/10ps
`default_nettype none

module branch_predictor
  import bp_types_pkg::*;
  import fetch_pkg::*;
#(
  parameter int INDEX_BITS = 3  // Table index width
) (
  input  wire logic     clk,
  input  wire logic     rst,
  input  wire logic     enable,   // Low freezes writes, zeroes reads
  input  wire pc_t      pc,       // Current fetch PC
  input  wire resolve_t resolve,  // Update packet from decode
  output predict_t      pred      // Answer for pc
);

  ////////////////////////////////////////////////////////////
  // Index and tag split
  ////////////////////////////////////////////////////////////
  logic [INDEX_BITS-1:0] rd_idx;     // Fetch side index
  logic [TAG_BITS-1:0]   rd_tag;     // Fetch side tag
  logic [INDEX_BITS-1:0] wr_idx;     // Resolve side index
  logic [TAG_BITS-1:0]   wr_tag;     // Resolve side tag
  logic                  bht_wen;    // Gated BHT strobe
  logic                  btb_wen;    // Gated BTB strobe
  logic [INDEX_BITS-1:0] bht_raddr;  // Shared BHT read address
  bht_entry_t            bht_rd;
  btb_entry_t            btb_rd;
  bht_entry_t            bht_wr;
  btb_entry_t            btb_wr;
  logic                  bht_hit;    // Fetch PC owns the BHT entry
  logic                  btb_hit;    // Fetch PC owns the BTB entry
  logic                  wr_match;   // Resolved PC owns the BHT entry
  bp_state_t             new_state;  // Counter to write back

  assign rd_idx  = pc[INDEX_BITS:1];          // PC[0] always zero
  assign rd_tag  = pc[15 -: TAG_BITS];
  assign wr_idx  = resolve.pc[INDEX_BITS:1];
  assign wr_tag  = resolve.pc[15 -: TAG_BITS];
  assign bht_wen = enable & resolve.wen_bht;
  assign btb_wen = enable & resolve.wen_btb;

  // BHT read output is masked during a write, so the port looks up the
  // resolved entry for the write-side tag check in that cycle
  assign bht_raddr = bht_wen ? wr_idx : rd_idx;

  ////////////////////////////////////////////////////////////
  // Tables
  ////////////////////////////////////////////////////////////
  tagged_table #(.INDEX_BITS(INDEX_BITS), .entry_t(bht_entry_t)) u_bht (
    .clk      (clk),
    .rst      (rst),
    .rd_index (bht_raddr),
    .wr_index (wr_idx),
    .wen      (bht_wen),
    .wr_entry (bht_wr),
    .rd_entry (bht_rd)
  );

  tagged_table #(.INDEX_BITS(INDEX_BITS), .entry_t(btb_entry_t)) u_btb (
    .clk      (clk),
    .rst      (rst),
    .rd_index (rd_idx),
    .wr_index (wr_idx),
    .wen      (btb_wen),
    .wr_entry (btb_wr),
    .rd_entry (btb_rd)
  );

  ////////////////////////////////////////////////////////////
  // Counter update
  ////////////////////////////////////////////////////////////
  assign wr_match = bht_rd.valid && (bht_rd.tag == wr_tag);

  always_comb begin
    case (resolve.prediction)
      STRONG_NOT_TAKEN: new_state = resolve.taken ? WEAK_NOT_TAKEN : STRONG_NOT_TAKEN;
      WEAK_NOT_TAKEN:   new_state = !wr_match ? STRONG_NOT_TAKEN :
                                    (resolve.taken ? WEAK_TAKEN : STRONG_NOT_TAKEN);
      WEAK_TAKEN:       new_state = !wr_match ? STRONG_NOT_TAKEN :
                                    (resolve.taken ? STRONG_TAKEN : WEAK_NOT_TAKEN);
      default:          new_state = !wr_match ? STRONG_NOT_TAKEN :   // Strong taken
                                    (resolve.taken ? STRONG_TAKEN : WEAK_TAKEN);
    endcase
  end

  assign bht_wr = '{valid: 1'b1, tag: wr_tag, state: new_state};
  assign btb_wr = '{valid: 1'b1, tag: wr_tag, target: resolve.target};

  ////////////////////////////////////////////////////////////
  // Prediction
  ////////////////////////////////////////////////////////////
  assign bht_hit = bht_rd.valid && (bht_rd.tag == rd_tag);
  assign btb_hit = btb_rd.valid && (btb_rd.tag == rd_tag);

  always_comb begin
    pred = '0;  // Strong not taken and target zero
    if (enable && !bht_wen) begin
      pred.prediction = bht_rd.state;         // Raw counter without the tag gate
      pred.taken      = bht_hit & bht_rd.state[1];
    end
    if (enable && !btb_wen && btb_hit) begin
      pred.target = btb_rd.target;
    end
  end

  // The entry stored at the fetch index must be valid, tagged by this PC and taken
  a_taken_hit : assert property (
    @(posedge clk) disable iff (rst)
    pred.taken |-> (u_bht.mem[rd_idx].valid && u_bht.mem[rd_idx].tag == rd_tag &&
                    u_bht.mem[rd_idx].state[1])
  ) else $error("taken without a matching BHT entry");

endmodule

`default_nettype wire

//--- rtl/fetch_pc_unit.sv
// Fetch PC unit
// Program counter, next-PC selection between redirect, predicted target
// and PC+2, and the IF/ID pipeline register
`timescale 1ns/10ps
`default_nettype none

module fetch_pc_unit
  import fetch_pkg::*;
#(
  parameter pc_t RESET_PC = 16'h0000  // PC after reset
) (
  input  wire logic     clk,
  input  wire logic     rst,
  input  wire logic     enable,   // Low holds PC and IF/ID
  input  wire predict_t pred,     // Predictor answer for pc
  input  wire resolve_t resolve,  // Redirect from decode
  output pc_t           pc,       // Current fetch PC
  output if_id_t        if_id     // Instruction handed to decode
);

  ////////////////////////////////////////////////////////////
  // Next PC
  ////////////////////////////////////////////////////////////
  pc_t pc_seq;   // Fall-through address
  pc_t next_pc;  // Selected address for the next edge

  assign pc_seq = pc + 16'd2;  // 16-bit instructions

  // Decode redirect beats the prediction
  always_comb begin
    if (resolve.redirect) begin
      next_pc = resolve.redirect_pc;
    end else if (pred.taken) begin
      next_pc = pred.target;
    end else begin
      next_pc = pc_seq;
    end
  end

  ////////////////////////////////////////////////////////////
  // PC register
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= RESET_PC;
    end else if (enable) begin
      pc <= next_pc;
    end
  end

  ////////////////////////////////////////////////////////////
  // IF/ID register
  ////////////////////////////////////////////////////////////
  // Trails pc by one cycle, carries the counter it was fetched with
  always_ff @(posedge clk) begin
    if (rst) begin
      if_id <= '0;
    end else if (enable) begin
      if_id.pc         <= pc;
      if_id.prediction <= pred.prediction;
    end
  end

  ////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////
  // Targets and redirects from BTB and decode must stay halfword aligned
  a_pc_aligned : assert property (
    @(posedge clk) disable iff (rst)
    !pc[0]
  ) else $error("fetch PC lost halfword alignment");

endmodule

`default_nettype wire

//--- rtl/fetch_pkg.sv
// Fetch stage types
// PC type, predictor answer, IF/ID register contents and the
// resolve packet sent back by decode
`default_nettype none

package fetch_pkg;

  import bp_types_pkg::*;

  ////////////////////////////////////////////////////////////
  // Program counter
  ////////////////////////////////////////////////////////////
  typedef logic [15:0] pc_t;  // Halfword aligned, bit 0 stays low

  ////////////////////////////////////////////////////////////
  // Predictor to fetch
  ////////////////////////////////////////////////////////////
  typedef struct packed {
    logic      taken;       // Tag hit and counter in taken half
    bp_state_t prediction;  // Raw counter read at this index
    pc_t       target;      // BTB target, zero on a miss
  } predict_t;

  ////////////////////////////////////////////////////////////
  // Fetch to decode
  ////////////////////////////////////////////////////////////
  typedef struct packed {
    pc_t       pc;          // PC of the fetched instruction
    bp_state_t prediction;  // Counter seen when it was fetched
  } if_id_t;

  ////////////////////////////////////////////////////////////
  // Decode to fetch and predictor
  ////////////////////////////////////////////////////////////
  typedef struct packed {
    pc_t       pc;           // Resolved branch PC
    bp_state_t prediction;   // Counter it was fetched with
    logic      taken;        // Actual outcome
    pc_t       target;       // Actual target
    logic      wen_bht;      // Write BHT next edge
    logic      wen_btb;      // Write BTB next edge
    logic      redirect;     // Override next PC
    pc_t       redirect_pc;  // PC to restart from
  } resolve_t;

endpackage

`default_nettype wire

//--- rtl/tagged_table.sv
// Direct-mapped tagged table
// Combinational read port, one synchronous write port, payload given by
// a type parameter so the same block holds BHT and BTB entries
`timescale 1ns/10ps
`default_nettype none

module tagged_table #(
  parameter int  INDEX_BITS = 3,            // Entries = 2**INDEX_BITS
  parameter type entry_t    = logic [7:0]   // Stored entry layout
) (
  input  wire logic                  clk,
  input  wire logic                  rst,       // Clears every entry
  input  wire logic [INDEX_BITS-1:0] rd_index,  // Read address
  input  wire logic [INDEX_BITS-1:0] wr_index,  // Write address
  input  wire logic                  wen,       // Write strobe
  input  wire entry_t                wr_entry,  // Entry to store
  output entry_t                     rd_entry   // Entry at rd_index
);

  ////////////////////////////////////////////////////////////
  // Storage
  ////////////////////////////////////////////////////////////
  localparam int DEPTH = 2 ** INDEX_BITS;

  entry_t mem [DEPTH];  // One entry per index

  // All-zero entry has valid low, so reset empties the table
  always_ff @(posedge clk) begin
    if (rst) begin
      mem <= '{default: '0};
    end else if (wen) begin
      mem[wr_index] <= wr_entry;  // Visible to reads next cycle
    end
  end

  ////////////////////////////////////////////////////////////
  // Read port
  ////////////////////////////////////////////////////////////
  // No bypass, a same-cycle write is seen one cycle later
  always_comb begin
    rd_entry = mem[rd_index];
  end

  ////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////
  // An X index would corrupt an unknown entry
  a_wr_index_known : assert property (
    @(posedge clk) disable iff (rst)
    wen |-> !$isunknown(wr_index)
  ) else $error("tagged_table write with unknown index");

endmodule

`default_nettype wire

//--- sources.f
rtl/bp_types_pkg.sv
rtl/fetch_pkg.sv
rtl/tagged_table.sv
rtl/branch_predictor.sv
rtl/fetch_pc_unit.sv
rtl/branch_fetch_top.sv
verif/tb_branch_fetch.sv

//--- verif/branch_input.txt
# test en res_pc res_pred res_taken res_target wen_bht wen_btb redirect redirect_pc
#   exp_pc exp_taken exp_pred exp_target exp_if_pc exp_if_pred (all hex, one line per cycle)
1 1 0000 0 0 0000 0 0 0 0000  0000 0 0 0000 0000 0
1 1 0000 0 0 0000 0 0 0 0000  0002 0 0 0000 0000 0
1 1 0000 0 0 0000 0 0 0 0000  0004 0 0 0000 0002 0
2 1 0010 0 1 0040 1 1 0 0000  0006 0 0 0000 0004 0
2 1 0010 1 1 0040 1 0 0 0000  0008 0 0 0000 0006 0
2 1 0010 2 1 0040 1 0 0 0000  000a 0 0 0000 0008 0
2 1 0010 3 1 0040 1 0 0 0000  000c 0 0 0000 000a 0
2 1 0010 3 0 0040 1 0 0 0000  000e 0 0 0000 000c 0
2 1 0000 0 0 0000 0 0 0 0000  0010 1 2 0040 000e 0
3 1 0000 0 0 0000 0 0 0 0000  0040 0 2 0000 0010 2
3 1 0040 2 1 0000 1 0 0 0000  0042 0 0 0000 0040 2
4 1 0010 0 1 0000 1 0 1 0010  0044 0 0 0000 0042 0
4 1 0010 0 0 0060 0 1 1 0010  0010 0 1 0000 0044 0
4 1 0010 1 1 0060 1 0 0 0000  0010 0 0 0060 0010 1
5 1 0000 0 0 0000 0 0 1 0010  0012 0 0 0000 0010 0
5 1 0000 0 0 0000 0 0 1 0020  0010 1 2 0060 0012 0
5 0 0000 0 0 0000 0 0 1 0030  0020 0 0 0000 0010 2
5 0 0000 0 0 0000 0 0 0 0000  0020 0 0 0000 0010 2
5 1 0000 0 0 0000 0 0 0 0000  0020 0 2 0000 0010 2
5 1 0000 0 0 0000 0 0 0 0000  0022 0 0 0000 0020 2

//--- verif/tb_branch_fetch.sv
// Testbench for the branch fetch top level
// Replays the vector file cycle by cycle in the role of the decode stage
// and checks pc, the prediction and the IF/ID register
`timescale 1ns/10ps
`default_nettype none

module tb_branch_fetch
  import bp_types_pkg::*;
  import fetch_pkg::*;
;

  ////////////////////////////////////////////////////////////
  // Vector format
  ////////////////////////////////////////////////////////////
  localparam string VEC_FILE = "verif/branch_input.txt";

  typedef struct packed {
    logic [15:0] test;         // Test number
    logic        en;           // Stage enable
    resolve_t    res;          // Packet driven as decode
    logic [15:0] exp_pc;       // Expected fetch PC
    logic [15:0] exp_taken;
    logic [15:0] exp_pred;     // Expected counter read
    logic [15:0] exp_target;
    logic [15:0] exp_if_pc;    // Expected IF/ID contents
    logic [15:0] exp_if_pred;
  } vector_t;

  logic     clk;
  logic     rst;
  logic     enable;
  resolve_t resolve;
  pc_t      pc;
  predict_t pred;
  if_id_t   if_id;

  vector_t vec_q[$];          // All vectors from the file
  logic    loaded;            // Vectors read, watchdog may start
  int      test_checks;
  int      test_errors;
  int      total_errors;
  int      tests_passed;
  int      tests_failed;

  branch_fetch_top #(.INDEX_BITS(3), .RESET_PC(16'h0000)) DUT (
    .clk     (clk),
    .rst     (rst),
    .enable  (enable),
    .resolve (resolve),
    .pc      (pc),
    .pred    (pred),
    .if_id   (if_id)
  );

  always #50 clk = ~clk;  // 100 ns period

  ////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////
  task automatic check_value(input string name, input logic [15:0] expected,
                             input logic [15:0] actual);
    test_checks++;
    if (actual !== expected) begin
      $display("ERROR: time %0t, %s expected %h, actual %h", $time, name, expected, actual);
      test_errors++;
      total_errors++;
    end
  endtask

  task automatic load_vectors();
    int          fd;
    int          n;
    string       line;
    vector_t     v;
    logic [15:0] f_test, f_en, f_rpc, f_rpred, f_rtk, f_rtgt, f_wbht, f_wbtb;
    logic [15:0] f_redir, f_rdpc, f_pc, f_tk, f_pred, f_tgt, f_ifpc, f_ifpred;
    fd = $fopen(VEC_FILE, "r");
    if (fd == 0) begin
      $display("Could not open the vector file %s", VEC_FILE);
    end else begin
      while ($fgets(line, fd) != 0) begin
        if (line.len() > 1 && line.getc(0) != "#") begin  // Skip blanks and comments
          n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                      f_test, f_en, f_rpc, f_rpred, f_rtk, f_rtgt, f_wbht, f_wbtb,
                      f_redir, f_rdpc, f_pc, f_tk, f_pred, f_tgt, f_ifpc, f_ifpred);
          if (n == 16) begin
            v                    = '0;
            v.test               = f_test;
            v.en                 = f_en[0];
            v.res.pc             = f_rpc;
            v.res.prediction     = bp_state_t'(f_rpred[1:0]);
            v.res.taken          = f_rtk[0];
            v.res.target         = f_rtgt;
            v.res.wen_bht        = f_wbht[0];
            v.res.wen_btb        = f_wbtb[0];
            v.res.redirect       = f_redir[0];
            v.res.redirect_pc    = f_rdpc;
            v.exp_pc             = f_pc;
            v.exp_taken          = f_tk;
            v.exp_pred           = f_pred;
            v.exp_target         = f_tgt;
            v.exp_if_pc          = f_ifpc;
            v.exp_if_pred        = f_ifpred;
            vec_q.push_back(v);
          end else begin
            $display("Vector line has %0d fields instead of 16: %s", n, line);
            total_errors++;
          end
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic check_outputs(input vector_t v);
    check_value("pc", v.exp_pc, pc);
    check_value("pred.taken", v.exp_taken, {15'd0, pred.taken});
    check_value("pred.prediction", v.exp_pred, {14'd0, pred.prediction});
    check_value("pred.target", v.exp_target, pred.target);
    check_value("if_id.pc", v.exp_if_pc, if_id.pc);
    check_value("if_id.prediction", v.exp_if_pred, {14'd0, if_id.prediction});
  endtask

  task automatic finish_test(input logic [15:0] num);
    if (test_errors == 0) begin
      tests_passed++;
      $display("Test %0d done: %0d checks, no errors", num, test_checks);
    end else begin
      tests_failed++;
      $display("Test %0d done: %0d checks, %0d errors", num, test_checks, test_errors);
    end
    test_checks = 0;
    test_errors = 0;
  endtask

  // Entered 5 ns after an edge, leaves 5 ns after the next one
  task automatic run_vectors();
    vector_t     v;
    logic [15:0] cur_test;
    cur_test = vec_q[0].test;
    foreach (vec_q[i]) begin
      v = vec_q[i];
      if (v.test != cur_test) begin
        finish_test(cur_test);
        cur_test = v.test;
      end
      enable  = v.en;
      resolve = v.res;
      #90;                  // Sample 5 ns before the edge
      check_outputs(v);
      @(posedge clk);
      #5;
    end
    finish_test(cur_test);
  endtask

  ////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////
  initial begin
    clk          = 1'b0;
    rst          = 1'b1;
    enable       = 1'b0;
    resolve      = '0;
    loaded       = 1'b0;
    test_checks  = 0;
    test_errors  = 0;
    total_errors = 0;
    tests_passed = 0;
    tests_failed = 0;
    load_vectors();
    if (vec_q.size() == 0) begin
      $display("No vectors could be read, nothing was tested");
      $display("Test failures found");
      $finish;
    end else begin
      loaded = 1'b1;
      repeat (2) @(posedge clk);  // Reset for 2 cycles
      #5;
      rst = 1'b0;
      run_vectors();
      $display("Summary: %0d tests passed, %0d tests failed, %0d errors",
               tests_passed, tests_failed, total_errors);
      if (total_errors == 0) begin
        $display("All tests passed!");
      end else begin
        $display("Test failures found");
      end
      $finish;
    end
  end

  // Vectors plus reset and slack, one period each
  initial begin
    wait (loaded);
    #((vec_q.size() + 10) * 100);
    $display("Timeout: the vectors did not finish in the expected time");
    $display("Test failures found");
    $finish;
  end

endmodule

`default_nettype wire
